//--- common/lc3b_pkg.sv
package lc3b_pkg;

	//////////////////////////////////////////////////
	// basic widths
	//////////////////////////////////////////////////

	typedef logic [15:0] word_t;
	typedef logic [2:0] reg_idx_t;

	// n, z, p from msb to lsb
	typedef logic [2:0] nzp_t;

	//////////////////////////////////////////////////
	// instruction encodings
	//////////////////////////////////////////////////

	typedef enum logic [3:0] {
		op_br  = 4'b0000,
		op_add = 4'b0001,
		op_and = 4'b0101,
		op_not = 4'b1001,
		op_ldr = 4'b0110,
		op_str = 4'b0111
	} opcode_t;

	typedef enum logic [1:0] {
		alu_add,
		alu_and,
		alu_not,
		alu_pass
	} alu_op_t;

	//////////////////////////////////////////////////
	// control word and stage boundaries
	//////////////////////////////////////////////////

	typedef struct packed {
		opcode_t opcode;
		alu_op_t alu_op;
		logic use_imm;
		logic read_memory;
		logic write_memory;
		logic load_regfile;
		logic load_cc;
		logic wb_from_mem;
	} ctrl_t;

	typedef struct packed {
		logic valid;
		ctrl_t ctrl;
		word_t sr1;
		word_t sr2;
		word_t imm;
		reg_idx_t dest;
	} de_ex_t;

	typedef struct packed {
		logic valid;
		ctrl_t ctrl;
		word_t alu_out;
		word_t address;
		word_t store_data;
		reg_idx_t dest;
	} ex_mem_t;

	typedef struct packed {
		logic load;
		reg_idx_t dest;
		word_t data;
	} wb_t;

endpackage

//--- logic/regfile.sv
module regfile import lc3b_pkg::*;
(
	input logic clk,
	input logic rst,
	input wb_t wb,
	input reg_idx_t src_a,
	input reg_idx_t src_b,
	output word_t reg_a,
	output word_t reg_b
);

	word_t regs [8];

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			for (int i = 0; i < 8; i++)
				regs[i] <= '0;
		end
		else if (wb.load)
			regs[wb.dest] <= wb.data;
	end

	// write-through, so a reader in the write cycle sees the new value
	assign reg_a = (wb.load && wb.dest == src_a) ? wb.data : regs[src_a];
	assign reg_b = (wb.load && wb.dest == src_b) ? wb.data : regs[src_b];

endmodule

//--- fetch/fetch_stage.sv
module fetch_stage import lc3b_pkg::*;
#(
	parameter word_t RESET_PC = 16'h0000
)
(
	input logic clk,
	input logic rst,
	input logic advance,
	input logic mem_resp_a,
	input word_t mem_rdata_a,
	output logic mem_read_a,
	output word_t mem_address_a,
	output word_t instr,
	output word_t pc_next,
	output logic instr_ready
);

	word_t pc;
	word_t instr_q;
	logic held;

	assign pc_next = pc + 16'd2;
	assign mem_address_a = pc;

	// a fresh response goes straight through, a held one comes from instr_q
	assign instr = held ? instr_q : mem_rdata_a;
	assign instr_ready = held | mem_resp_a;

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			pc <= RESET_PC;
			held <= 1'b0;
			mem_read_a <= 1'b0;
		end
		else
		begin
			if (advance)
				pc <= pc_next;
			if (advance)
				held <= 1'b0;
			else if (mem_resp_a)
				held <= 1'b1;
			// drop after the response, re-arm once the word has been consumed
			mem_read_a <= ~mem_resp_a & (~held | advance);
		end
	end

	always_ff @(posedge clk)
	begin
		if (mem_resp_a)
			instr_q <= mem_rdata_a;
	end

	// a held word means the port must stay quiet until the next advance
	assert property (@(posedge clk) disable iff (rst) held |-> !mem_read_a);

endmodule

//--- decode/decode_stage.sv
module decode_stage import lc3b_pkg::*;
(
	input logic clk,
	input logic rst,
	input logic advance,
	input word_t instr,
	input wb_t wb,
	output de_ex_t de_ex
);

	opcode_t opcode;
	ctrl_t ctrl;
	logic valid;
	reg_idx_t src_b;
	word_t imm;
	word_t sr1_value;
	word_t sr2_value;

	assign opcode = opcode_t'(instr[15:12]);

	//////////////////////////////////////////////////
	// control decode
	//////////////////////////////////////////////////

	always_comb
	begin
		ctrl = '0;
		ctrl.opcode = opcode;
		ctrl.alu_op = alu_pass;
		valid = 1'b1;
		src_b = instr[2:0];
		// imm5 by default
		imm = {{11{instr[4]}}, instr[4:0]};
		case (opcode)
			op_add:
			begin
				ctrl.alu_op = alu_add;
				ctrl.use_imm = instr[5];
				ctrl.load_regfile = 1'b1;
				ctrl.load_cc = 1'b1;
			end
			op_and:
			begin
				ctrl.alu_op = alu_and;
				ctrl.use_imm = instr[5];
				ctrl.load_regfile = 1'b1;
				ctrl.load_cc = 1'b1;
			end
			op_not:
			begin
				ctrl.alu_op = alu_not;
				ctrl.load_regfile = 1'b1;
				ctrl.load_cc = 1'b1;
			end
			op_ldr:
			begin
				imm = {{9{instr[5]}}, instr[5:0], 1'b0};
				ctrl.read_memory = 1'b1;
				ctrl.load_regfile = 1'b1;
				ctrl.load_cc = 1'b1;
				ctrl.wb_from_mem = 1'b1;
			end
			op_str:
			begin
				// store data comes from the SR field in bits 11:9
				imm = {{9{instr[5]}}, instr[5:0], 1'b0};
				src_b = instr[11:9];
				ctrl.write_memory = 1'b1;
			end
			// NOP and everything outside the subset
			default: valid = 1'b0;
		endcase
	end

	regfile i_regfile
	(
		.clk,
		.rst,
		.wb,
		.src_a(instr[8:6]),
		.src_b,
		.reg_a(sr1_value),
		.reg_b(sr2_value)
	);

	always_ff @(posedge clk)
	begin
		if (rst)
			de_ex.valid <= 1'b0;
		else if (advance)
		begin
			de_ex.valid <= valid;
			de_ex.ctrl <= ctrl;
			de_ex.sr1 <= sr1_value;
			de_ex.sr2 <= sr2_value;
			de_ex.imm <= imm;
			de_ex.dest <= instr[11:9];
		end
	end

endmodule

//--- execute/execute_stage.sv
module execute_stage import lc3b_pkg::*;
(
	input logic clk,
	input logic rst,
	input logic advance,
	input de_ex_t de_ex,
	output ex_mem_t ex_mem
);

	word_t operand_b;
	word_t alu_out;
	word_t address;

	assign operand_b = de_ex.ctrl.use_imm ? de_ex.imm : de_ex.sr2;

	always_comb
	begin
		case (de_ex.ctrl.alu_op)
			alu_add: alu_out = de_ex.sr1 + operand_b;
			alu_and: alu_out = de_ex.sr1 & operand_b;
			alu_not: alu_out = ~de_ex.sr1;
			default: alu_out = de_ex.sr1;
		endcase
	end

	// base register plus the already shifted offset6
	assign address = de_ex.sr1 + de_ex.imm;

	//////////////////////////////////////////////////
	// execute to memory register
	//////////////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (rst)
			ex_mem.valid <= 1'b0;
		else if (advance)
		begin
			ex_mem.valid <= de_ex.valid;
			ex_mem.ctrl <= de_ex.ctrl;
			ex_mem.alu_out <= alu_out;
			ex_mem.address <= address;
			ex_mem.store_data <= de_ex.sr2;
			ex_mem.dest <= de_ex.dest;
		end
	end

endmodule

//--- memory/memory_stage.sv
module memory_stage import lc3b_pkg::*;
(
	input logic clk,
	input logic rst,
	input logic advance,
	input ex_mem_t ex_mem,
	input logic mem_resp_b,
	input word_t mem_rdata_b,
	output logic mem_read_b,
	output logic mem_write_b,
	output logic [1:0] mem_wmask_b,
	output word_t mem_address_b,
	output word_t mem_wdata_b,
	output logic data_ready,
	output wb_t wb
);

	logic access;
	logic done;
	word_t load_q;
	word_t load_data;
	word_t wb_data;
	nzp_t cc;
	nzp_t cc_next;

	//////////////////////////////////////////////////
	// data port
	//////////////////////////////////////////////////

	assign access = ex_mem.valid & (ex_mem.ctrl.read_memory | ex_mem.ctrl.write_memory);

	// request stays up until the response, done keeps it low afterwards
	assign mem_read_b = ex_mem.valid & ex_mem.ctrl.read_memory & ~done;
	assign mem_write_b = ex_mem.valid & ex_mem.ctrl.write_memory & ~done;
	assign mem_wmask_b = 2'b11;
	assign mem_address_b = ex_mem.address;
	assign mem_wdata_b = ex_mem.store_data;

	assign data_ready = ~access | done | mem_resp_b;

	always_ff @(posedge clk)
	begin
		if (rst)
			done <= 1'b0;
		else if (advance)
			done <= 1'b0;
		else if (mem_resp_b)
			done <= 1'b1;
	end

	always_ff @(posedge clk)
	begin
		if (mem_resp_b && !done)
			load_q <= mem_rdata_b;
	end

	assign load_data = done ? load_q : mem_rdata_b;

	//////////////////////////////////////////////////
	// write-back and condition codes
	//////////////////////////////////////////////////

	assign wb_data = ex_mem.ctrl.wb_from_mem ? load_data : ex_mem.alu_out;

	assign wb.load = ex_mem.valid & ex_mem.ctrl.load_regfile & advance;
	assign wb.dest = ex_mem.dest;
	assign wb.data = wb_data;

	always_comb
	begin
		if (wb_data[15])
			cc_next = 3'b100;
		else if (wb_data == '0)
			cc_next = 3'b010;
		else
			cc_next = 3'b001;
	end

	always_ff @(posedge clk)
	begin
		if (rst)
			cc <= 3'b010;
		else if (ex_mem.valid && ex_mem.ctrl.load_cc && advance)
			cc <= cc_next;
	end

	assert property (@(posedge clk) disable iff (rst) !(mem_read_b && mem_write_b));

endmodule

//--- logic/stall_control.sv
module stall_control
(
	input logic clk,
	input logic rst,
	input logic instr_ready,
	input logic data_ready,
	output logic advance
);

	logic run;

	// run stays low through reset and for the first cycle after it
	always_ff @(posedge clk)
	begin
		if (rst)
			run <= 1'b0;
		else
			run <= 1'b1;
	end

	// both memories have answered, so every stage moves
	assign advance = run & ~rst & instr_ready & data_ready;

	assert property (@(posedge clk) rst |-> !advance);

endmodule

//--- logic/lc3b_pipeline.sv
module lc3b_pipeline import lc3b_pkg::*;
#(
	parameter word_t RESET_PC = 16'h0000
)
(
	input logic clk,
	input logic rst,

	// instruction port
	output logic mem_read_a,
	output word_t mem_address_a,
	input word_t mem_rdata_a,
	input logic mem_resp_a,

	// data port
	output logic mem_read_b,
	output logic mem_write_b,
	output logic [1:0] mem_wmask_b,
	output word_t mem_address_b,
	output word_t mem_wdata_b,
	input word_t mem_rdata_b,
	input logic mem_resp_b
);

	logic advance;
	logic instr_ready;
	logic data_ready;
	word_t instr;
	de_ex_t de_ex;
	ex_mem_t ex_mem;
	wb_t wb;

	//////////////////////////////////////////////////
	// stages
	//////////////////////////////////////////////////

	fetch_stage #(.RESET_PC(RESET_PC)) i_fetch
	(
		.clk,
		.rst,
		.advance,
		.mem_resp_a,
		.mem_rdata_a,
		.mem_read_a,
		.mem_address_a,
		.instr,
		.pc_next(),
		.instr_ready
	);

	decode_stage i_decode
	(
		.clk,
		.rst,
		.advance,
		.instr,
		.wb,
		.de_ex
	);

	execute_stage i_execute
	(
		.clk,
		.rst,
		.advance,
		.de_ex,
		.ex_mem
	);

	memory_stage i_memory
	(
		.clk,
		.rst,
		.advance,
		.ex_mem,
		.mem_resp_b,
		.mem_rdata_b,
		.mem_read_b,
		.mem_write_b,
		.mem_wmask_b,
		.mem_address_b,
		.mem_wdata_b,
		.data_ready,
		.wb
	);

	stall_control i_stall
	(
		.clk,
		.rst,
		.instr_ready,
		.data_ready,
		.advance
	);

endmodule

//--- sim/tb_lc3b_pipeline.sv
module tb_lc3b_pipeline import lc3b_pkg::*;
();

	timeunit 1ns;
	timeprecision 100ps;

	localparam word_t RESET_PC = 16'h0040;
	// reset program, alu program, load/store program three times, spacing program
	localparam int TOTAL_INSTR = 6 + 15 + 3 * 10 + 8;
	localparam int TIMEOUT_CYCLES = 40 * TOTAL_INSTR;

	logic clk;
	logic rst;
	logic mem_read_a;
	logic mem_resp_a;
	word_t mem_address_a;
	word_t mem_rdata_a;
	logic mem_read_b;
	logic mem_write_b;
	logic mem_resp_b;
	logic [1:0] mem_wmask_b;
	word_t mem_address_b;
	word_t mem_wdata_b;
	word_t mem_rdata_b;

	word_t imem [256];
	word_t dmem [256];
	word_t wr_addr [16];
	word_t wr_data [16];
	int writes = 0;
	int errors = 0;
	int cycles = 0;
	int seed = 66;
	string test_name = "idle";

	// memory model state
	int cnt_a = 0;
	int cnt_b = 0;
	word_t addr_a;
	word_t addr_b;
	logic write_b;
	word_t next_fetch;
	word_t first_fetch;
	int fetches = 0;
	int data_reqs = 0;
	int rst_cycles = 0;
	logic fixed_latency = 1'b0;

	lc3b_pipeline #(.RESET_PC(RESET_PC)) i_dut
	(
		.clk,
		.rst,
		.mem_read_a,
		.mem_address_a,
		.mem_rdata_a,
		.mem_resp_a,
		.mem_read_b,
		.mem_write_b,
		.mem_wmask_b,
		.mem_address_b,
		.mem_wdata_b,
		.mem_rdata_b,
		.mem_resp_b
	);

	always #50 clk = ~clk;

	always @(posedge clk)
	begin
		cycles++;
		if (cycles >= TIMEOUT_CYCLES)
		begin
			$display("timeout in %s: pipeline stopped after %0d cycles", test_name, cycles);
			$display("errors: %0d", errors + 1);
			$display("Result: FAILED");
			$finish;
		end
	end

	task automatic check_word(string what, word_t expected, word_t actual);
		assert (actual === expected)
		else
		begin
			errors++;
			$display("Mismatch %s %s: expected %h, actual %h", test_name, what, expected, actual);
		end
	endtask

	function automatic int pick_latency();
		if (fixed_latency)
			return 1;
		return 1 + int'({$random(seed)} % 3);
	endfunction

	// address-unique fill for the data array
	function automatic word_t fill_word(int idx);
		return {8'(idx), 8'(~idx)};
	endfunction

	//////////////////////////////////////////////////
	// instruction encoders
	//////////////////////////////////////////////////

	function automatic word_t encode_reg(opcode_t op, int dr, int sr1, int sr2);
		return {op, 3'(dr), 3'(sr1), 3'b000, 3'(sr2)};
	endfunction

	function automatic word_t encode_imm(opcode_t op, int dr, int sr1, int imm);
		return {op, 3'(dr), 3'(sr1), 1'b1, 5'(imm)};
	endfunction

	function automatic word_t encode_not(int dr, int sr);
		return {op_not, 3'(dr), 3'(sr), 6'b111111};
	endfunction

	function automatic word_t encode_mem(opcode_t op, int r, int base, int offset);
		return {op, 3'(r), 3'(base), 6'(offset)};
	endfunction

	//////////////////////////////////////////////////
	// two-port memory model
	//////////////////////////////////////////////////

	task automatic serve_instr();
		if (cnt_a == 0 && mem_read_a)
		begin
			if (fetches == 0)
				first_fetch = mem_address_a;
			check_word("fetch address", next_fetch, mem_address_a);
			addr_a = mem_address_a;
			next_fetch = mem_address_a + 16'd2;
			cnt_a = pick_latency();
			fetches++;
		end
		if (cnt_a > 0)
		begin
			assert (mem_read_a && mem_address_a == addr_a)
			else
			begin
				errors++;
				$display("%s: instruction request dropped or moved while waiting", test_name);
			end
			cnt_a--;
			if (cnt_a == 0)
			begin
				mem_rdata_a = imem[addr_a[8:1]];
				mem_resp_a = 1'b1;
			end
		end
	endtask

	task automatic serve_data();
		if (cnt_b == 0 && (mem_read_b || mem_write_b))
		begin
			addr_b = mem_address_b;
			write_b = mem_write_b;
			cnt_b = pick_latency();
			data_reqs++;
		end
		if (cnt_b > 0)
		begin
			assert ((write_b ? mem_write_b : mem_read_b) && mem_address_b == addr_b)
			else
			begin
				errors++;
				$display("%s: data request dropped or changed while waiting", test_name);
			end
			cnt_b--;
			if (cnt_b == 0)
			begin
				mem_resp_b = 1'b1;
				if (write_b)
				begin
					check_word("write mask", 16'd3, 16'(mem_wmask_b));
					dmem[addr_b[8:1]] = mem_wdata_b;
					if (writes < 16)
					begin
						wr_addr[writes] = addr_b;
						wr_data[writes] = mem_wdata_b;
					end
					writes++;
				end
				else
					mem_rdata_b = dmem[addr_b[8:1]];
			end
		end
	endtask

	always @(negedge clk)
	begin
		mem_resp_a = 1'b0;
		mem_resp_b = 1'b0;
		if (rst)
		begin
			cnt_a = 0;
			cnt_b = 0;
			fetches = 0;
			data_reqs = 0;
			next_fetch = RESET_PC;
			rst_cycles++;
			// first reset cycle still shows the old state
			if (rst_cycles > 1)
			begin
				assert (!mem_read_a && !mem_read_b && !mem_write_b)
				else
				begin
					errors++;
					$display("%s: memory request active while in reset", test_name);
				end
			end
		end
		else
		begin
			rst_cycles = 0;
			serve_instr();
			serve_data();
		end
	end

	//////////////////////////////////////////////////
	// program control
	//////////////////////////////////////////////////

	task automatic start_reset();
		@(negedge clk);
		rst = 1'b1;
		@(negedge clk);
		writes = 0;
		for (int i = 0; i < 256; i++)
		begin
			dmem[i] = fill_word(i);
			imem[i] = 16'h0000;
		end
	endtask

	task automatic release_reset();
		repeat (4) @(negedge clk);
		rst = 1'b0;
	endtask

	task automatic put_instr(int slot, word_t word);
		imem[(RESET_PC >> 1) + slot] = word;
	endtask

	// extra cycles afterwards catch a repeated store
	task automatic wait_for_writes(int count);
		while (writes < count)
			@(negedge clk);
		repeat (20) @(negedge clk);
		check_word("write count", 16'(count), 16'(writes));
	endtask

	task automatic write_ls_program();
		put_instr(0, encode_mem(op_ldr, 1, 0, 3));
		put_instr(1, encode_mem(op_ldr, 2, 0, 5));
		put_instr(2, encode_imm(op_add, 6, 0, 8));
		put_instr(4, encode_mem(op_str, 1, 0, 24));
		put_instr(5, encode_mem(op_str, 2, 6, 10));
		put_instr(6, encode_mem(op_ldr, 3, 6, -2));
		put_instr(9, encode_mem(op_str, 3, 0, 25));
	endtask

	// three loads and three stores, each requested exactly once
	task automatic check_ls_stores();
		// base plus twice the offset6 field
		check_word("store 0 address", 16'(0 + 2 * 24), wr_addr[0]);
		check_word("store 1 address", 16'(8 + 2 * 10), wr_addr[1]);
		check_word("store 2 address", 16'(0 + 2 * 25), wr_addr[2]);
		check_word("store 0 data", fill_word(3), wr_data[0]);
		check_word("store 1 data", fill_word(5), wr_data[1]);
		check_word("store 2 data", fill_word((8 - 2 * 2) / 2), wr_data[2]);
		check_word("data word 24", fill_word(3), dmem[24]);
		check_word("data requests", 16'd6, 16'(data_reqs));
	endtask

	//////////////////////////////////////////////////
	// directed tests
	//////////////////////////////////////////////////

	task automatic reset_and_fetch();
		test_name = "reset_fetch";
		start_reset();
		release_reset();
		while (fetches < 6)
			@(negedge clk);
		check_word("first fetch", RESET_PC, first_fetch);
		check_word("data requests", 16'd0, 16'(data_reqs));
	endtask

	task automatic alu_forms();
		word_t a;
		word_t b;
		word_t expected [5];
		test_name = "alu_forms";
		a = 16'd13;
		b = 16'hfffa;
		// imm5 operands sign-extended by hand
		expected[0] = a + b;
		expected[1] = a & 16'hfffc;
		expected[2] = ~b;
		expected[3] = a & b;
		expected[4] = b + 16'hfffd;
		start_reset();
		put_instr(0, encode_imm(op_add, 1, 0, 13));
		put_instr(1, encode_imm(op_add, 2, 0, -6));
		put_instr(4, encode_reg(op_add, 3, 1, 2));
		put_instr(5, encode_imm(op_and, 4, 1, -4));
		put_instr(6, encode_not(5, 2));
		put_instr(7, encode_mem(op_str, 3, 0, 16));
		put_instr(8, encode_mem(op_str, 4, 0, 17));
		put_instr(9, encode_mem(op_str, 5, 0, 18));
		put_instr(10, encode_reg(op_and, 6, 1, 2));
		put_instr(11, encode_imm(op_add, 7, 2, -3));
		put_instr(13, encode_mem(op_str, 6, 0, 19));
		put_instr(14, encode_mem(op_str, 7, 0, 20));
		release_reset();
		wait_for_writes(5);
		for (int i = 0; i < 5; i++)
			check_word($sformatf("store %0d", i), expected[i], dmem[16 + i]);
	endtask

	task automatic load_and_store();
		test_name = "load_store";
		start_reset();
		write_ls_program();
		release_reset();
		wait_for_writes(3);
		check_ls_stores();
	endtask

	task automatic writethrough_spacing();
		test_name = "spacing";
		start_reset();
		put_instr(0, encode_imm(op_add, 1, 0, 9));
		put_instr(1, encode_imm(op_add, 2, 0, 4));
		put_instr(2, encode_imm(op_and, 3, 0, 0));
		put_instr(3, encode_imm(op_add, 4, 1, 5));
		put_instr(6, encode_mem(op_str, 4, 0, 30));
		put_instr(7, encode_mem(op_str, 2, 0, 31));
		release_reset();
		wait_for_writes(2);
		check_word("consumer", 16'd9 + 16'd5, dmem[30]);
		check_word("independent", 16'd4, dmem[31]);
	endtask

	// same program at 1-cycle and at random latency, both held to the same stores
	task automatic backpressure_runs();
		test_name = "backpressure_fixed";
		fixed_latency = 1'b1;
		start_reset();
		write_ls_program();
		release_reset();
		wait_for_writes(3);
		check_ls_stores();
		test_name = "backpressure_random";
		fixed_latency = 1'b0;
		start_reset();
		write_ls_program();
		release_reset();
		wait_for_writes(3);
		check_ls_stores();
	endtask

	initial
	begin
		clk = 1'b0;
		rst = 1'b1;
		mem_resp_a = 1'b0;
		mem_rdata_a = '0;
		mem_resp_b = 1'b0;
		mem_rdata_b = '0;
		reset_and_fetch();
		alu_forms();
		load_and_store();
		writethrough_spacing();
		backpressure_runs();
		$display("checks complete, %0d errors", errors);
		if (errors == 0)
			$display("Result: PASSED");
		else
			$display("Result: FAILED");
		$finish;
	end

endmodule

//--- sources.f
common/lc3b_pkg.sv
logic/regfile.sv
fetch/fetch_stage.sv
decode/decode_stage.sv
execute/execute_stage.sv
memory/memory_stage.sv
logic/stall_control.sv
logic/lc3b_pipeline.sv
sim/tb_lc3b_pipeline.sv

//--- run.sh
#!/bin/sh
# build and run the LC-3b pipeline testbench with Verilator
rm -f sim.log
verilator --binary --timing --assert --timescale 1ns/100ps -Wno-fatal \
	-f sources.f --top-module tb_lc3b_pipeline -o tb_sim > build.log 2>&1 \
	&& ./obj_dir/tb_sim > sim.log 2>&1 \
	|| echo "build or simulation step returned an error"
cat build.log sim.log 2>/dev/null | tail -n 20
grep -q "^Result: PASSED$" sim.log 2>/dev/null \
	&& echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }
